// File: filelist.f
common/dcache_pkg.sv
dcache/dcache_data.sv
dcache/dcache_tag.sv
dcache/dcache_ctrl.sv
hw/store_buffer.sv
hw/mem_port.sv
hw/dcache_top.sv
verification/dcache_props.sv
verification/tb_dcache.sv

// File: verification/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_LANES  = 16;
    localparam int SB_DEPTH   = 4;
    localparam int NUM_REQ    = 2000;
    localparam int CLK_PERIOD = 20;
    localparam int IDX_W      = $clog2(NUM_LANES);
    localparam int TAG_W      = 32 - IDX_W - 4;
    localparam logic [31:0] BASE = 32'h2000_0000;   // 1 KiB test region

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic                    req_i;
    logic                    req_we_i;
    logic [31:0]             req_addr_i;
    dcache_pkg::memop_type_e req_type_i;
    logic [31:0]             req_wdata_i;
    logic                    rsp_valid_o;
    logic [31:0]             rsp_data_o;
    logic                    busy_o;
    logic                    mem_req_o;
    logic                    mem_we_o;
    logic [31:0]             mem_addr_o;
    logic [31:0]             mem_wdata_o;
    dcache_pkg::memop_type_e mem_type_o;
    logic                    mem_rsp_i;
    logic [127:0]            mem_rdata_i;

    integer               seed;
    integer               lat_seed;
    logic [7:0]           mem_bytes [1024];
    logic [7:0]           ref_bytes [1024];
    logic [NUM_LANES-1:0] exp_valid;          // Expected tag state of the cache
    logic [TAG_W-1:0]     exp_tag [NUM_LANES];
    logic [65:0]          store_q [$];        // {addr, size, masked data}
    int                   refill_cnt;
    logic [31:0]          last_refill;
    logic                 mem_pending;
    int                   full_stalls;

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    dcache_top #(.NUM_LANES(NUM_LANES), .SB_DEPTH(SB_DEPTH)) DUT (.*);

    bind dcache_top dcache_props u_props (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_we_i    (req_we_i),
        .busy_i      (busy_o),
        .rsp_valid_i (rsp_valid_o),
        .mem_req_i   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

    function automatic logic [7:0] fill_byte(input logic [9:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h3c;
    endfunction

    function automatic int size_bytes(input dcache_pkg::memop_type_e t);
        case (t)
            dcache_pkg::BYTE: return 1;
            dcache_pkg::HALF: return 2;
            default:          return 4;
        endcase
    endfunction

    function automatic logic [31:0] size_mask(input dcache_pkg::memop_type_e t);
        case (t)
            dcache_pkg::BYTE: return 32'h0000_00ff;
            dcache_pkg::HALF: return 32'h0000_ffff;
            default:          return 32'hffff_ffff;
        endcase
    endfunction

    // Little endian, zero extended
    function automatic logic [31:0] ref_read(input logic [9:0] off,
                                             input dcache_pkg::memop_type_e t);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = ref_bytes[10'(off + k)];
        end
        return w & size_mask(t);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin : watchdog
        #((NUM_REQ * 40 + 20) * CLK_PERIOD);
        $display("Timeout: the requests did not complete in the expected time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    // Protocol checker on the DUT
    initial begin : assertion_watch
        wait (DUT.u_props.fail_count != 0);
        $display("A protocol assertion on the DUT failed");
        $display("sim failed");
        $fatal(1, "assertion failure");
    end

    // Memory with 1 to 8 cycles of latency, one request at a time
    initial begin : memory
        logic [31:0]  addr;
        logic [127:0] lane;
        logic [65:0]  exp;
        logic         is_write;
        int           lat;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                addr        = mem_addr_o;
                is_write    = mem_we_o;
                mem_pending = 1'b1;
                check_value("mem_addr_o region", addr & ~32'h3ff, BASE);
                if (is_write) begin
                    check_value("store queue not empty", store_q.size() != 0, 1);
                    exp = store_q.pop_front();
                    check_value("mem_addr_o", addr, exp[65:34]);
                    check_value("mem_type_o", mem_type_o, exp[33:32]);
                    check_value("mem_wdata_o", mem_wdata_o & size_mask(mem_type_o), exp[31:0]);
                    for (int k = 0; k < size_bytes(mem_type_o); k++) begin
                        mem_bytes[10'(addr[9:0] + k)] = mem_wdata_o[8*k +: 8];
                    end
                end else begin
                    check_value("mem_addr_o offset", addr[3:0], 0);
                    refill_cnt++;
                    last_refill = addr;
                    for (int k = 0; k < 16; k++) begin
                        lane[8*k +: 8] = mem_bytes[{addr[9:4], 4'(k)}];
                    end
                end
                lat = 1 + ($unsigned($random(lat_seed)) % 8);
                repeat (lat) @(negedge clk_i);
                mem_rdata_i = is_write ? '0 : lane;
                mem_rsp_i   = 1'b1;
                @(negedge clk_i);
                mem_rsp_i   = 1'b0;
                mem_pending = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0]             addr;
        logic [31:0]             data;
        logic [9:0]              offs;
        logic [IDX_W-1:0]        idx;
        logic                    we;
        logic                    hit;
        dcache_pkg::memop_type_e size;
        int                      cnt_before;
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_type_i  = dcache_pkg::WORD;
        req_wdata_i = '0;
        mem_rsp_i   = 1'b0;
        mem_rdata_i = '0;
        seed        = 32'hbf87_7dc8;
        lat_seed    = seed ^ 32'h1234_5678;
        exp_valid   = '0;
        refill_cnt  = 0;
        mem_pending = 1'b0;
        full_stalls = 0;
        for (int a = 0; a < 1024; a++) begin
            mem_bytes[a] = fill_byte(10'(a));
            ref_bytes[a] = fill_byte(10'(a));
        end
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("rsp_valid_o after reset", rsp_valid_o, 0);
        check_value("mem_req_o after reset", mem_req_o, 0);
        check_value("busy_o after reset", busy_o, 0);

        for (int n = 0; n < NUM_REQ; n++) begin
            data = $random(seed);
            we   = $random(seed);
            case ($unsigned($random(seed)) % 3)
                0:       size = dcache_pkg::BYTE;
                1:       size = dcache_pkg::HALF;
                default: size = dcache_pkg::WORD;
            endcase
            offs = $random(seed);
            if (size == dcache_pkg::HALF) offs[0] = 1'b0;
            if (size == dcache_pkg::WORD) offs[1:0] = 2'b00;
            addr = BASE | 32'(offs);
            idx  = addr[4 +: IDX_W];
            hit  = exp_valid[idx] && (exp_tag[idx] == addr[31 -: TAG_W]);
            if ($unsigned($random(seed)) % 4 == 0) repeat (3) @(negedge clk_i);
            while (busy_o) begin     // Only a full buffer can hold off here
                full_stalls++;
                @(negedge clk_i);
            end
            req_i       = 1'b1;
            req_we_i    = we;
            req_addr_i  = addr;
            req_type_i  = size;
            req_wdata_i = data;
            cnt_before  = refill_cnt;
            if (we) begin
                store_q.push_back({addr, size, data & size_mask(size)});
                for (int k = 0; k < size_bytes(size); k++) begin
                    ref_bytes[10'(offs + k)] = data[8*k +: 8];
                end
            end
            @(negedge clk_i);
            req_i = 1'b0;
            if (we) begin
                check_value("rsp_valid_o after store", rsp_valid_o, 0);
            end else if (hit) begin
                check_value("rsp_valid_o on load hit", rsp_valid_o, 1);
                check_value("rsp_data_o", rsp_data_o, ref_read(offs, size));
                check_value("refill reads on load hit", refill_cnt, cnt_before);
            end else begin
                check_value("rsp_valid_o after load miss", rsp_valid_o, 0);
                while (!rsp_valid_o) begin   // Busy until the response
                    check_value("busy_o during load miss", busy_o, 1);
                    @(negedge clk_i);
                end
                check_value("rsp_data_o", rsp_data_o, ref_read(offs, size));
                check_value("refill reads on load miss", refill_cnt, cnt_before + 1);
                check_value("refill address", last_refill, {addr[31:4], 4'b0000});
                exp_valid[idx] = 1'b1;
                exp_tag[idx]   = addr[31 -: TAG_W];
            end
        end

        while (store_q.size() != 0 || mem_pending) @(negedge clk_i);
        check_value("busy_o stalls from a full buffer", full_stalls != 0, 1);
        for (int a = 0; a < 1024; a++) begin
            check_value($sformatf("mem_bytes[%0d]", a), mem_bytes[a], ref_bytes[a]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: verification/dcache_props.sv
`timescale 1ns/1ps

module dcache_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic req_we_i,
    input logic busy_i,
    input logic rsp_valid_i,
    input logic mem_req_i,
    input logic mem_rsp_i
);

    logic        outstanding;   // Memory request waiting for its response
    int unsigned fail_count = 0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding <= 1'b0;
        end else if (mem_req_i) begin
            outstanding <= 1'b1;
        end else if (mem_rsp_i) begin
            outstanding <= 1'b0;
        end
    end

    req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> !busy_i)
        else begin
            $error("request strobe while busy");
            fail_count++;
        end

    second_mem_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i |-> !outstanding)
        else begin
            $error("memory request while another is outstanding");
            fail_count++;
        end

    // A load that does not stall is a hit
    hit_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !req_we_i) ##1 !busy_i |-> rsp_valid_i)
        else begin
            $error("load hit response not one cycle after the request");
            fail_count++;
        end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_LANES = 16,
    parameter int SB_DEPTH  = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  logic                             req_we_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] req_addr_i,
    input  dcache_pkg::memop_type_e          req_type_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0] req_wdata_i,
    output logic                             rsp_valid_o,
    output logic [dcache_pkg::WORD_SIZE-1:0] rsp_data_o,
    output logic                             busy_o,
    output logic                             mem_req_o,
    output logic                             mem_we_o,
    output logic [dcache_pkg::ADDR_SIZE-1:0] mem_addr_o,
    output logic [dcache_pkg::WORD_SIZE-1:0] mem_wdata_o,
    output dcache_pkg::memop_type_e          mem_type_o,
    input  logic                             mem_rsp_i,
    input  logic [dcache_pkg::LANE_SIZE-1:0] mem_rdata_i
);

    logic [$clog2(NUM_LANES)-1:0]     index;
    logic [dcache_pkg::ADDR_SIZE-1:0] look_addr;
    logic [dcache_pkg::BYTE_SIZE-1:0] look_byte;
    dcache_pkg::memop_type_e          look_type;
    logic [dcache_pkg::WORD_SIZE-1:0] rdata;
    logic                             hit;
    logic                             data_wr;
    logic                             data_refill;
    logic                             sb_push;
    logic                             sb_pop;
    logic                             sb_full;
    logic                             sb_empty;
    logic [dcache_pkg::ADDR_SIZE-1:0] sb_addr;
    dcache_pkg::memop_type_e          sb_type;
    logic [dcache_pkg::WORD_SIZE-1:0] sb_wdata;
    logic                             refill_req;
    logic [dcache_pkg::ADDR_SIZE-1:0] refill_addr;
    logic                             refill_done;
    logic [dcache_pkg::LANE_SIZE-1:0] refill_lane;

    // While busy the arrays look at the miss address and read the aligned word
    assign look_addr = busy_o ? refill_addr : req_addr_i;
    assign look_byte = busy_o ? {refill_addr[dcache_pkg::BYTE_SIZE-1:2], 2'b00}
                              : req_addr_i[dcache_pkg::BYTE_SIZE-1:0];
    assign look_type = busy_o ? dcache_pkg::WORD : req_type_i;

    dcache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .req_we_i      (req_we_i),
        .req_addr_i    (req_addr_i),
        .req_type_i    (req_type_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o),
        .busy_o        (busy_o),
        .hit_i         (hit),
        .rdata_i       (rdata),
        .wr_o          (data_wr),
        .refill_o      (data_refill),
        .sb_push_o     (sb_push),
        .sb_full_i     (sb_full),
        .sb_empty_i    (sb_empty),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_done_i (refill_done)
    );

    dcache_tag #(.NUM_LANES(NUM_LANES)) u_tag (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .addr_i   (look_addr),
        .refill_i (data_refill),
        .hit_o    (hit),
        .index_o  (index)
    );

    dcache_data #(.NUM_LANES(NUM_LANES)) u_data (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (data_wr),
        .refill_i (data_refill),
        .index_i  (index),
        .byte_i   (look_byte),
        .type_i   (look_type),
        .wdata_i  (req_wdata_i),
        .lane_i   (refill_lane),
        .rdata_o  (rdata)
    );

    store_buffer #(.SB_DEPTH(SB_DEPTH)) u_sb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (sb_push),
        .push_addr_i  (req_addr_i),
        .push_type_i  (req_type_i),
        .push_wdata_i (req_wdata_i),
        .pop_i        (sb_pop),
        .head_addr_o  (sb_addr),
        .head_type_o  (sb_type),
        .head_wdata_o (sb_wdata),
        .empty_o      (sb_empty),
        .full_o       (sb_full)
    );

    mem_port u_mem_port (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .sb_empty_i    (sb_empty),
        .sb_addr_i     (sb_addr),
        .sb_type_i     (sb_type),
        .sb_wdata_i    (sb_wdata),
        .sb_pop_o      (sb_pop),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_done_o (refill_done),
        .refill_lane_o (refill_lane),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_type_o    (mem_type_o),
        .mem_rsp_i     (mem_rsp_i),
        .mem_rdata_i   (mem_rdata_i)
    );

endmodule

// File: hw/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             sb_empty_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] sb_addr_i,
    input  dcache_pkg::memop_type_e          sb_type_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0] sb_wdata_i,
    output logic                             sb_pop_o,
    input  logic                             refill_req_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] refill_addr_i,
    output logic                             refill_done_o,
    output logic [dcache_pkg::LANE_SIZE-1:0] refill_lane_o,
    output logic                             mem_req_o,
    output logic                             mem_we_o,
    output logic [dcache_pkg::ADDR_SIZE-1:0] mem_addr_o,
    output logic [dcache_pkg::WORD_SIZE-1:0] mem_wdata_o,
    output dcache_pkg::memop_type_e          mem_type_o,
    input  logic                             mem_rsp_i,
    input  logic [dcache_pkg::LANE_SIZE-1:0] mem_rdata_i
);

    typedef enum logic {
        IDLE,
        OUTSTANDING
    } state_e;

    state_e state_q;
    logic   is_refill_q;   // Kind of the request in flight
    logic   issue;
    logic   done;

    assign issue = (state_q == IDLE) && (refill_req_i || !sb_empty_i);
    assign done  = (state_q == OUTSTANDING) && mem_rsp_i;

    assign sb_pop_o      = done && !is_refill_q;
    assign refill_done_o = done && is_refill_q;
    assign refill_lane_o = mem_rdata_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            is_refill_q <= 1'b0;
            mem_req_o   <= 1'b0;
        end else begin
            mem_req_o <= issue;
            if (issue) begin
                state_q     <= OUTSTANDING;
                is_refill_q <= refill_req_i;   // Refill first
            end else if (done) begin
                state_q <= IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            mem_we_o    <= !refill_req_i;
            mem_wdata_o <= sb_wdata_i;
            if (refill_req_i) begin
                mem_addr_o <= {refill_addr_i[dcache_pkg::ADDR_SIZE-1:dcache_pkg::BYTE_SIZE],
                               {dcache_pkg::BYTE_SIZE{1'b0}}};
                mem_type_o <= dcache_pkg::WORD;
            end else begin
                mem_addr_o <= sb_addr_i;
                mem_type_o <= sb_type_i;
            end
        end
    end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/1ps

module store_buffer #(
    parameter int SB_DEPTH = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             push_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] push_addr_i,
    input  dcache_pkg::memop_type_e          push_type_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0] push_wdata_i,
    input  logic                             pop_i,
    output logic [dcache_pkg::ADDR_SIZE-1:0] head_addr_o,
    output dcache_pkg::memop_type_e          head_type_o,
    output logic [dcache_pkg::WORD_SIZE-1:0] head_wdata_o,
    output logic                             empty_o,
    output logic                             full_o
);

    localparam int PTR_W = $clog2(SB_DEPTH);

    logic [dcache_pkg::ADDR_SIZE-1:0] addr_mem  [SB_DEPTH];
    dcache_pkg::memop_type_e          type_mem  [SB_DEPTH];
    logic [dcache_pkg::WORD_SIZE-1:0] wdata_mem [SB_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == (PTR_W+1)'(SB_DEPTH));

    assign head_addr_o  = addr_mem[rd_ptr];
    assign head_type_o  = type_mem[rd_ptr];
    assign head_wdata_o = wdata_mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            addr_mem[wr_ptr]  <= push_addr_i;
            type_mem[wr_ptr]  <= push_type_i;
            wdata_mem[wr_ptr] <= push_wdata_i;
        end
    end

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  logic                             req_we_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] req_addr_i,
    input  dcache_pkg::memop_type_e          req_type_i,
    output logic                             rsp_valid_o,
    output logic [dcache_pkg::WORD_SIZE-1:0] rsp_data_o,
    output logic                             busy_o,
    input  logic                             hit_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0] rdata_i,
    output logic                             wr_o,
    output logic                             refill_o,
    output logic                             sb_push_o,
    input  logic                             sb_full_i,
    input  logic                             sb_empty_i,
    output logic                             refill_req_o,
    output logic [dcache_pkg::ADDR_SIZE-1:0] refill_addr_o,
    input  logic                             refill_done_i
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        REFILL
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [dcache_pkg::ADDR_SIZE-1:0] miss_addr_q;
    dcache_pkg::memop_type_e          miss_type_q;
    logic                             load_req;
    logic                             store_req;
    logic                             refill_rsp;

    // During a miss the data array returns the aligned word, the size is picked here
    function automatic logic [dcache_pkg::WORD_SIZE-1:0] pick_word(
        input logic [dcache_pkg::WORD_SIZE-1:0] word,
        input logic [1:0]                       off,
        input dcache_pkg::memop_type_e          size
    );
        logic [dcache_pkg::WORD_SIZE-1:0] res;
        case (size)
            dcache_pkg::BYTE: res = {{(dcache_pkg::WORD_SIZE-8){1'b0}}, word[8*off +: 8]};
            dcache_pkg::HALF: res = {{(dcache_pkg::WORD_SIZE-16){1'b0}},
                                     word[16*off[1] +: 16]};
            default:          res = word;
        endcase
        return res;
    endfunction

    assign load_req   = req_i && !req_we_i && (state_q == IDLE);
    assign store_req  = req_i && req_we_i && (state_q == IDLE);
    assign refill_rsp = (state_q == REFILL) && hit_i;   // Tag written by the refill

    assign busy_o        = (state_q != IDLE) || sb_full_i;
    assign wr_o          = store_req && hit_i;
    assign sb_push_o     = store_req;  // Write-through, no allocate
    assign refill_o      = refill_done_i;
    assign refill_req_o  = (state_q == REFILL) && !hit_i;
    assign refill_addr_o = miss_addr_q;   // Offset dropped by mem_port

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load_req && !hit_i) begin
                    state_d = sb_empty_i ? REFILL : DRAIN;
                end
            end
            DRAIN: begin
                if (sb_empty_i) state_d = REFILL;   // Earlier stores now in memory
            end
            REFILL: begin
                if (hit_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            rsp_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_o <= (load_req && hit_i) || refill_rsp;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_req && !hit_i) begin
            miss_addr_q <= req_addr_i;
            miss_type_q <= req_type_i;
        end
        if (load_req) begin
            rsp_data_o <= rdata_i;
        end else if (refill_rsp) begin
            rsp_data_o <= pick_word(rdata_i, miss_addr_q[1:0], miss_type_q);
        end
    end

endmodule

// File: dcache/dcache_tag.sv
`timescale 1ns/1ps

module dcache_tag #(
    parameter int NUM_LANES = 16
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [dcache_pkg::ADDR_SIZE-1:0] addr_i,
    input  logic                             refill_i,
    output logic                             hit_o,
    output logic [$clog2(NUM_LANES)-1:0]     index_o
);

    localparam int INDEX_SIZE = $clog2(NUM_LANES);
    localparam int TAG_SIZE   = dcache_pkg::ADDR_SIZE - INDEX_SIZE - dcache_pkg::BYTE_SIZE;

    logic [NUM_LANES-1:0] valid;
    logic [TAG_SIZE-1:0]  tags [NUM_LANES];
    logic [TAG_SIZE-1:0]  addr_tag;

    assign index_o  = addr_i[dcache_pkg::BYTE_SIZE +: INDEX_SIZE];
    assign addr_tag = addr_i[dcache_pkg::ADDR_SIZE-1 -: TAG_SIZE];

    assign hit_o = valid[index_o] && (tags[index_o] == addr_tag);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid <= '0;    // All lines invalid
        end else if (refill_i) begin
            valid[index_o] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tags[index_o] <= addr_tag;
        end
    end

endmodule

// File: dcache/dcache_data.sv
`timescale 1ns/1ps

module dcache_data #(
    parameter int NUM_LANES = 16
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 wr_i,
    input  logic                                 refill_i,
    input  logic [$clog2(NUM_LANES)-1:0]         index_i,
    input  logic [dcache_pkg::BYTE_SIZE-1:0]     byte_i,
    input  dcache_pkg::memop_type_e              type_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0]     wdata_i,
    input  logic [dcache_pkg::LANE_SIZE-1:0]     lane_i,
    output logic [dcache_pkg::WORD_SIZE-1:0]     rdata_o
);

    localparam int OFF_W = dcache_pkg::BYTE_SIZE;
    localparam int WB    = dcache_pkg::WORD_BYTES;

    logic [NUM_LANES-1:0][dcache_pkg::LANE_BYTES-1:0][7:0] cache_data;
    logic [WB-1:0][7:0] rd_bytes;
    logic [WB-1:0]      byte_en;

    always_comb begin
        case (type_i)
            dcache_pkg::BYTE: byte_en = 4'b0001;
            dcache_pkg::HALF: byte_en = 4'b0011;
            dcache_pkg::WORD: byte_en = 4'b1111;
            default:          byte_en = '0;
        endcase
    end

    // Four bytes starting at the offset, wrapping inside the lane
    always_comb begin
        for (int k = 0; k < WB; k++) begin
            rd_bytes[k] = cache_data[index_i][byte_i + OFF_W'(k)];
        end
    end

    always_comb begin
        case (type_i)
            dcache_pkg::BYTE: rdata_o = {{(dcache_pkg::WORD_SIZE-8){1'b0}}, rd_bytes[0]};
            dcache_pkg::HALF: rdata_o = {{(dcache_pkg::WORD_SIZE-16){1'b0}},
                                         rd_bytes[1], rd_bytes[0]};
            dcache_pkg::WORD: rdata_o = rd_bytes;
            default:          rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cache_data <= '0;
        end else if (wr_i) begin     // Store hit wins over refill
            for (int k = 0; k < WB; k++) begin
                if (byte_en[k]) begin
                    cache_data[index_i][byte_i + OFF_W'(k)] <= wdata_i[8*k +: 8];
                end
            end
        end else if (refill_i) begin
            cache_data[index_i] <= lane_i;
        end
    end

endmodule

// File: common/dcache_pkg.sv
package dcache_pkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_type_e;

    parameter int WORD_SIZE = 32;
    parameter int ADDR_SIZE = 32;
    parameter int LANE_SIZE = 128;   // One cache line
    parameter int BYTE_SIZE = 4;     // Byte offset bits inside a lane

    parameter int WORD_BYTES = WORD_SIZE / 8;
    parameter int LANE_BYTES = LANE_SIZE / 8;

endpackage
